// File: sources.f
lsu_pkg.sv
mem_access_decode.sv
cache_op_decode.sv
lsu_apb_master.sv
lsu_top.sv
tb_apb_mem.sv
tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_lsu -f sources.f -o sim_lsu
./obj_dir/sim_lsu | tee sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "lsu simulation passed"
else
    echo "lsu simulation failed, see sim.log"
    exit 1
fi

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    localparam int paddr_w    = 16;
    localparam int kind_mem   = 0;
    localparam int kind_cacop = 1;
    localparam int kind_ibar  = 2;
    localparam int kind_none  = 3;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    logic [xlen-1:0]       ctr, rrj, imm, rrd;
    logic [excp_arg_w-1:0] excp_arg;
    logic                  resp_valid, resp_ale, cacop_valid, ibar;
    logic                  icache_opflag, dcache_opflag, l2cache_opflag;
    logic [xlen-1:0]       resp_data;
    logic [31:0]           cache_opcode;
    logic                  psel, penable, pwrite, pready, pslverr;
    logic [paddr_w-1:0]    paddr;
    logic [xlen-1:0]       pwdata, prdata;
    logic [3:0]            pstrb;

    // request table
    logic [31:0] tab_ctr [$];
    logic [31:0] tab_rrj [$];
    logic [31:0] tab_imm [$];
    logic [31:0] tab_rrd [$];
    logic [15:0] tab_excp [$];
    logic [31:0] tab_data [$];
    logic        tab_ale [$];
    int          tab_kind [$];
    logic [31:0] shadow [64]; // expected memory words

    lsu_top #(.PADDR_W(paddr_w)) DUT (.*);

    tb_apb_mem #(.ADDR_W(paddr_w), .SEED(32'h97fc)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_target(input cacop_target_e tgt, input logic ic, input logic dc,
                                input logic l2);
        logic [2:0] exp;
        case (tgt)
            tgt_icache: exp = 3'b100;
            tgt_dcache: exp = 3'b011; // dcache also hits l2
            tgt_l2:     exp = 3'b001;
            default:    exp = 3'b000;
        endcase
        if ({ic, dc, l2} !== exp) begin
            $display("Error: {icache_opflag,dcache_opflag,l2cache_opflag} got %h expected %h",
                     {ic, dc, l2}, exp);
            fail_run();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out after 50 cycles waiting for %s", what);
        fail_run();
    endtask

    function automatic logic [31:0] make_ctr(input logic [3:0] typ, input logic [4:0] sub);
        return {20'd0, sub, 3'd0, typ};
    endfunction

    task automatic push_entry(input logic [31:0] c, input logic [31:0] j, input logic [31:0] i,
                              input logic [31:0] d, input logic [15:0] arg,
                              input logic [31:0] data, input logic ale, input int kind);
        tab_ctr.push_back(c);
        tab_rrj.push_back(j);
        tab_imm.push_back(i);
        tab_rrd.push_back(d);
        tab_excp.push_back(arg);
        tab_data.push_back(data);
        tab_ale.push_back(ale);
        tab_kind.push_back(kind);
    endtask

    // expected result from little endian lanes and the shadow words
    task automatic add_mem(input logic [3:0] typ, input logic [4:0] sub,
                           input logic [31:0] base, input logic [31:0] ofs,
                           input logic [31:0] val);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] data;
        int          nbytes;
        logic        store;
        logic        ale;
        addr   = base + ofs;
        word   = shadow[addr[7:2]];
        data   = '0;
        nbytes = 4;
        if (typ == inst_type_mem && sub inside {sub_ld_b, sub_st_b, sub_ld_bu})
            nbytes = 1;
        if (typ == inst_type_mem && sub inside {sub_ld_h, sub_st_h, sub_ld_hu})
            nbytes = 2;
        store = (typ == inst_type_mem && sub inside {sub_st_b, sub_st_h, sub_st_w}) ||
                (typ == inst_type_atomic && sub == sub_sc_w);
        ale   = (int'(addr[1:0]) % nbytes) != 0;
        if (!ale && store) begin
            for (int b = 0; b < nbytes; b++)
                word[8 * (int'(addr[1:0]) + b) +: 8] = val[8 * b +: 8];
            shadow[addr[7:2]] = word;
            data = (typ == inst_type_atomic) ? 32'd1 : 32'd0; // sc.w success
        end else if (!ale) begin
            word = word >> (8 * int'(addr[1:0]));
            if (nbytes == 1)
                data = {{24{word[7] && sub == sub_ld_b}}, word[7:0]};
            else if (nbytes == 2)
                data = {{16{word[15] && sub == sub_ld_h}}, word[15:0]};
            else
                data = word;
        end
        push_entry(make_ctr(typ, sub), base, ofs, val, 16'd0, data, ale, kind_mem);
    endtask

    task automatic add_cacop(input cacop_target_e tgt, input logic [12:0] operand);
        push_entry(make_ctr(inst_type_mem, sub_cacop), 32'h1c, 32'h4, 32'h0,
                   {operand, tgt}, 32'd0, 1'b0, kind_cacop);
    endtask

    task automatic build_table();
        add_mem(inst_type_mem, sub_st_w, 32'h40, 32'h0, 32'h1234_5678);
        add_mem(inst_type_mem, sub_ld_w, 32'h40, 32'h0, 32'h0);
        add_mem(inst_type_atomic, sub_ll_w, 32'h30, 32'h10, 32'h0);
        add_mem(inst_type_mem, sub_st_w, 32'h90, 32'hffff_fff0, 32'hcafe_f00d); // negative imm
        add_mem(inst_type_mem, sub_ld_w, 32'h80, 32'h0, 32'h0);
        add_mem(inst_type_mem, sub_st_w, 32'h44, 32'h0, 32'h7654_3210);
        for (int k = 0; k < 4; k++) begin
            add_mem(inst_type_mem, sub_st_b, 32'h44, 32'(k), 32'hffff_ffc0 + 32'(k));
            add_mem(inst_type_mem, sub_ld_w, 32'h44, 32'h0, 32'h0);
        end
        add_mem(inst_type_mem, sub_st_w, 32'h48, 32'h0, 32'h0f1e_2d3c);
        for (int k = 0; k < 4; k += 2) begin
            add_mem(inst_type_mem, sub_st_h, 32'h48, 32'(k), 32'hdead_a500 + 32'(k));
            add_mem(inst_type_mem, sub_ld_w, 32'h48, 32'h0, 32'h0);
        end
        // bytes of both signs
        add_mem(inst_type_mem, sub_st_w, 32'h50, 32'h0, 32'h80f1_7f82);
        for (int k = 0; k < 4; k++) begin
            add_mem(inst_type_mem, sub_ld_b, 32'h50, 32'(k), 32'h0);
            add_mem(inst_type_mem, sub_ld_bu, 32'h50, 32'(k), 32'h0);
        end
        for (int k = 0; k < 4; k += 2) begin
            add_mem(inst_type_mem, sub_ld_h, 32'h50, 32'(k), 32'h0);
            add_mem(inst_type_mem, sub_ld_hu, 32'h50, 32'(k), 32'h0);
        end
        add_mem(inst_type_mem, sub_st_w, 32'h58, 32'h0, 32'h1357_9bdf);
        add_mem(inst_type_mem, sub_st_h, 32'h58, 32'h1, 32'hffff_ffff);
        add_mem(inst_type_mem, sub_st_h, 32'h58, 32'h3, 32'heeee_eeee);
        add_mem(inst_type_mem, sub_st_w, 32'h58, 32'h2, 32'hdddd_dddd);
        add_mem(inst_type_mem, sub_ld_h, 32'h58, 32'h1, 32'h0);
        add_mem(inst_type_mem, sub_ld_w, 32'h58, 32'h3, 32'h0);
        add_mem(inst_type_atomic, sub_sc_w, 32'h58, 32'h2, 32'h1111_1111);
        add_mem(inst_type_mem, sub_ld_w, 32'h58, 32'h0, 32'h0); // must be unchanged
        add_cacop(tgt_icache, 13'h00a5);
        add_cacop(tgt_dcache, 13'h1fff);
        add_cacop(tgt_l2, 13'h0321);
        push_entry(make_ctr(inst_type_ibar, 5'd0), 0, 0, 0, 16'd0, 0, 1'b0, kind_ibar);
        push_entry(make_ctr(4'd2, sub_ld_w), 32'h40, 0, 32'h55, 16'h7, 0, 1'b0, kind_none);
        push_entry(make_ctr(inst_type_mem, 5'd9), 32'h40, 0, 0, 16'h1, 0, 1'b0, kind_none);
        add_mem(inst_type_atomic, sub_sc_w, 32'h60, 32'h0, 32'h0bad_beef);
        add_mem(inst_type_mem, sub_ld_w, 32'h60, 32'h0, 32'h0);
    endtask

    task automatic run_request(input int n);
        int          cycles;
        logic        psel_seen;
        logic [15:0] arg;
        logic [31:0] opc;
        arg = tab_excp[n];
        @(posedge clk);
        req_valid <= 1'b1;
        ctr       <= tab_ctr[n];
        rrj       <= tab_rrj[n];
        imm       <= tab_imm[n];
        rrd       <= tab_rrd[n];
        excp_arg  <= arg;
        cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            cycles++;
            if (cycles == 50)
                timeout_fail("req_ready");
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0; // accepted at this edge
        cycles    = 0;
        psel_seen = 1'b0;
        @(negedge clk);
        while (!resp_valid) begin
            check_flag("req_ready", req_ready, 1'b0);
            psel_seen = psel_seen | psel;
            cycles++;
            if (cycles == 50)
                timeout_fail("resp_valid");
            @(negedge clk);
        end
        psel_seen = psel_seen | psel;
        opc = 32'd0;
        if (tab_kind[n] == kind_cacop)
            opc = {16'd0, arg};
        else if (tab_kind[n] == kind_ibar)
            opc = ibar_opcode;
        check_flag("req_ready", req_ready, 1'b0);
        check_flag("psel", psel_seen, tab_kind[n] == kind_mem && !tab_ale[n]);
        check_data("resp_data", resp_data, tab_data[n]);
        check_flag("resp_ale", resp_ale, tab_ale[n]);
        check_data("cache_opcode", cache_opcode, opc);
        check_flag("cacop_valid", cacop_valid, tab_kind[n] inside {kind_cacop, kind_ibar});
        check_flag("ibar", ibar, tab_kind[n] == kind_ibar);
        if (tab_kind[n] == kind_cacop) begin
            check_target(cacop_target_e'(arg[2:0]), icache_opflag, dcache_opflag,
                         l2cache_opflag);
        end else begin
            check_flag("icache_opflag", icache_opflag, tab_kind[n] == kind_ibar);
            check_flag("dcache_opflag", dcache_opflag, 1'b0);
            check_flag("l2cache_opflag", l2cache_opflag, 1'b0);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        ctr       = '0;
        rrj       = '0;
        imm       = '0;
        rrd       = '0;
        excp_arg  = '0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("req_ready", req_ready, 1'b1);
        check_flag("psel", psel, 1'b0);
        check_flag("penable", penable, 1'b0);
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("cacop_valid", cacop_valid, 1'b0);
        check_flag("ibar", ibar, 1'b0);
        for (int n = 0; n < tab_ctr.size(); n++)
            run_request(n);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb_apb_mem.sv
`timescale 1ns/1ps

module tb_apb_mem #(
    parameter int          ADDR_W = 16,
    parameter logic [31:0] SEED   = 32'h97fc
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [31:0]       pwdata,
    input  logic [3:0]        pstrb,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr
);

    logic [31:0] mem [64];
    logic [31:0] lfsr_q;
    logic [31:0] lfsr_a;
    logic [31:0] lfsr_b;
    logic [1:0]  wait_cnt;
    logic [5:0]  idx;

    // galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 64; i++)
            mem[i] <= (32'(i) * 32'h0405_0607) ^ 32'hc3a5_5a3c;
    end

    assign idx     = paddr[7:2];
    assign lfsr_a  = lfsr_step(lfsr_q);
    assign lfsr_b  = lfsr_step(lfsr_a);
    assign prdata  = mem[idx];
    assign pready  = psel && penable && (wait_cnt == 2'd0);
    assign pslverr = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q   <= SEED;
            wait_cnt <= 2'd0;
        end else if (psel && !penable) begin
            lfsr_q   <= lfsr_b; // one step per wait-state bit
            wait_cnt <= {lfsr_b[0], lfsr_a[0]};
        end else if (psel && penable && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (psel && penable && pready && pwrite) begin
            for (int b = 0; b < 4; b++)
                if (pstrb[b])
                    mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
        end
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int PADDR_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [xlen-1:0]       ctr,
    input  logic [xlen-1:0]       rrj,
    input  logic [xlen-1:0]       imm,
    input  logic [xlen-1:0]       rrd,
    input  logic [excp_arg_w-1:0] excp_arg,
    output logic                  resp_valid,
    output logic [xlen-1:0]       resp_data,
    output logic                  resp_ale,
    output logic                  cacop_valid,
    output logic                  icache_opflag,
    output logic                  dcache_opflag,
    output logic                  l2cache_opflag,
    output logic [31:0]           cache_opcode,
    output logic                  ibar,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [PADDR_W-1:0]    paddr,
    output logic [xlen-1:0]       pwdata,
    output logic [3:0]            pstrb,
    input  logic [xlen-1:0]       prdata,
    input  logic                  pready,
    input  logic                  pslverr
);

    logic [xlen-1:0]       ctr_q, rrj_q, imm_q, rrd_q;
    logic [excp_arg_w-1:0] excp_arg_q;
    logic                  mem_valid, mem_write, load_signed, atomic_sc, misaligned;
    logic [xlen-1:0]       mem_addr, mem_wdata;
    mem_size_e             mem_size;
    logic [3:0]            mem_wstrb;
    logic                  op_valid, icache_flag, dcache_flag, l2_flag, is_ibar;
    logic [31:0]           opcode;

    mem_access_decode u_mem_dec (
        .ctr(ctr_q), .rrj(rrj_q), .imm(imm_q), .rrd(rrd_q),
        .mem_valid(mem_valid), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
        .load_signed(load_signed), .atomic_sc(atomic_sc), .misaligned(misaligned)
    );

    cache_op_decode u_cop_dec (
        .ctr(ctr_q), .excp_arg(excp_arg_q),
        .op_valid(op_valid), .icache_flag(icache_flag), .dcache_flag(dcache_flag),
        .l2_flag(l2_flag), .opcode(opcode), .is_ibar(is_ibar)
    );

    lsu_apb_master #(.PADDR_W(PADDR_W)) u_master (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready),
        .ctr(ctr), .rrj(rrj), .imm(imm), .rrd(rrd), .excp_arg(excp_arg),
        .resp_valid(resp_valid), .resp_data(resp_data), .resp_ale(resp_ale),
        .cacop_valid(cacop_valid), .icache_opflag(icache_opflag),
        .dcache_opflag(dcache_opflag), .l2cache_opflag(l2cache_opflag),
        .cache_opcode(cache_opcode), .ibar(ibar),
        .ctr_q(ctr_q), .rrj_q(rrj_q), .imm_q(imm_q), .rrd_q(rrd_q), .excp_arg_q(excp_arg_q),
        .mem_valid(mem_valid), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_size(mem_size), .mem_wstrb(mem_wstrb), .mem_wdata(mem_wdata),
        .load_signed(load_signed), .atomic_sc(atomic_sc), .misaligned(misaligned),
        .op_valid(op_valid), .icache_flag(icache_flag), .dcache_flag(dcache_flag),
        .l2_flag(l2_flag), .opcode(opcode), .is_ibar(is_ibar),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

endmodule

// File: lsu_apb_master.sv
`timescale 1ns/1ps

module lsu_apb_master import lsu_pkg::*; #(
    parameter int PADDR_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // pipeline request
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [xlen-1:0]       ctr,
    input  logic [xlen-1:0]       rrj,
    input  logic [xlen-1:0]       imm,
    input  logic [xlen-1:0]       rrd,
    input  logic [excp_arg_w-1:0] excp_arg,
    // pipeline response
    output logic                  resp_valid,
    output logic [xlen-1:0]       resp_data,
    output logic                  resp_ale,
    output logic                  cacop_valid,
    output logic                  icache_opflag,
    output logic                  dcache_opflag,
    output logic                  l2cache_opflag,
    output logic [31:0]           cache_opcode,
    output logic                  ibar,
    // held instruction to decoders
    output logic [xlen-1:0]       ctr_q,
    output logic [xlen-1:0]       rrj_q,
    output logic [xlen-1:0]       imm_q,
    output logic [xlen-1:0]       rrd_q,
    output logic [excp_arg_w-1:0] excp_arg_q,
    // memory access decode
    input  logic                  mem_valid,
    input  logic                  mem_write,
    input  logic [xlen-1:0]       mem_addr,
    input  mem_size_e             mem_size,
    input  logic [3:0]            mem_wstrb,
    input  logic [xlen-1:0]       mem_wdata,
    input  logic                  load_signed,
    input  logic                  atomic_sc,
    input  logic                  misaligned,
    // cache op decode
    input  logic                  op_valid,
    input  logic                  icache_flag,
    input  logic                  dcache_flag,
    input  logic                  l2_flag,
    input  logic [31:0]           opcode,
    input  logic                  is_ibar,
    // apb master
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [PADDR_W-1:0]    paddr,
    output logic [xlen-1:0]       pwdata,
    output logic [3:0]            pstrb,
    input  logic [xlen-1:0]       prdata,
    input  logic                  pready,
    input  logic                  pslverr
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access,
        st_respond
    } state_e;

    state_e          state;
    state_e          state_nxt;
    logic            go_apb;
    logic [xlen-1:0] rdata_q;
    logic            slverr_q;
    logic [xlen-1:0] rdata_shift;
    logic [xlen-1:0] load_data;

    assign go_apb = mem_valid & ~misaligned;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (req_valid) state_nxt = st_setup;
            st_setup:   state_nxt = go_apb ? st_access : st_idle; // else answer now
            st_access:  if (pready) state_nxt = st_respond;
            st_respond: state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            ctr_q      <= ctr;
            rrj_q      <= rrj;
            imm_q      <= imm;
            rrd_q      <= rrd;
            excp_arg_q <= excp_arg;
        end
        if (state == st_access && pready) begin
            rdata_q  <= prdata;
            slverr_q <= pslverr;
        end
    end

    assign req_ready = (state == st_idle);

    // apb drive, held by the request registers
    assign psel    = (state == st_setup && go_apb) || state == st_access;
    assign penable = (state == st_access);
    assign pwrite  = mem_write;
    assign paddr   = {mem_addr[PADDR_W-1:2], 2'b00}; // word aligned, lanes via pstrb
    assign pwdata  = mem_wdata;
    assign pstrb   = mem_write ? mem_wstrb : 4'b0000;

    // load data back to lane 0
    assign rdata_shift = rdata_q >> {mem_addr[1:0], 3'b000};

    always_comb begin
        case (mem_size)
            size_byte: load_data = {{24{load_signed & rdata_shift[7]}}, rdata_shift[7:0]};
            size_half: load_data = {{16{load_signed & rdata_shift[15]}}, rdata_shift[15:0]};
            default:   load_data = rdata_shift;
        endcase
    end

    always_comb begin
        resp_data = '0;
        if (go_apb) begin
            if (atomic_sc)
                resp_data = 32'd1; // sc.w always succeeds
            else if (!mem_write)
                resp_data = load_data;
        end
    end

    assign resp_valid     = (state == st_setup && !go_apb) || state == st_respond;
    assign resp_ale       = resp_valid && (misaligned || (state == st_respond && slverr_q));
    assign cacop_valid    = resp_valid & op_valid;
    assign icache_opflag  = resp_valid & icache_flag;
    assign dcache_opflag  = resp_valid & dcache_flag;
    assign l2cache_opflag = resp_valid & l2_flag;
    assign ibar           = resp_valid & is_ibar;
    assign cache_opcode   = opcode;

    // access phase only after a selected cycle
    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel && $past(psel));

    a_apb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwdata));

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid);

    // the two decoders never claim the same instruction
    a_decode_excl: assert property (@(posedge clk) disable iff (!rst_n)
        state != st_idle |-> !(mem_valid && op_valid));

endmodule

// File: cache_op_decode.sv
`timescale 1ns/1ps

module cache_op_decode import lsu_pkg::*; (
    input  logic [xlen-1:0]       ctr,
    input  logic [excp_arg_w-1:0] excp_arg,
    output logic                  op_valid,
    output logic                  icache_flag,
    output logic                  dcache_flag,
    output logic                  l2_flag,
    output logic [31:0]           opcode,
    output logic                  is_ibar
);

    logic [3:0]    inst_type;
    logic [4:0]    subtype;
    cacop_target_e target;

    assign inst_type = ctr[type_msb:type_lsb];
    assign subtype   = ctr[subtype_msb:subtype_lsb];
    assign target    = cacop_target_e'(excp_arg[2:0]);

    always_comb begin
        op_valid    = 1'b0;
        icache_flag = 1'b0;
        dcache_flag = 1'b0;
        l2_flag     = 1'b0;
        opcode      = '0;
        is_ibar     = 1'b0;
        if (inst_type == inst_type_mem && subtype == sub_cacop) begin
            op_valid = 1'b1;
            opcode   = {{(32 - excp_arg_w){1'b0}}, excp_arg};
            case (target)
                tgt_icache: icache_flag = 1'b1;
                tgt_dcache: begin
                    dcache_flag = 1'b1;
                    l2_flag     = 1'b1; // dcache op also reaches l2
                end
                tgt_l2:     l2_flag = 1'b1;
                default: ; // reserved target, no cache touched
            endcase
        end else if (inst_type == inst_type_ibar) begin
            op_valid    = 1'b1;
            icache_flag = 1'b1;
            opcode      = ibar_opcode;
            is_ibar     = 1'b1;
        end
    end

endmodule

// File: mem_access_decode.sv
`timescale 1ns/1ps

module mem_access_decode import lsu_pkg::*; (
    input  logic [xlen-1:0] ctr,
    input  logic [xlen-1:0] rrj,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] rrd,
    output logic            mem_valid,
    output logic            mem_write,
    output logic [xlen-1:0] mem_addr,
    output mem_size_e       mem_size,
    output logic [3:0]      mem_wstrb,
    output logic [xlen-1:0] mem_wdata,
    output logic            load_signed,
    output logic            atomic_sc,
    output logic            misaligned
);

    logic [3:0] inst_type;
    logic [4:0] subtype;
    logic [1:0] offset;
    logic [3:0] lane_mask;
    logic       bad_align;

    assign inst_type = ctr[type_msb:type_lsb];
    assign subtype   = ctr[subtype_msb:subtype_lsb];
    assign mem_addr  = rrj + imm;
    assign offset    = mem_addr[1:0];

    always_comb begin
        mem_valid   = 1'b0;
        mem_write   = 1'b0;
        mem_size    = size_byte;
        load_signed = 1'b0;
        atomic_sc   = 1'b0;
        if (inst_type == inst_type_mem) begin
            case (subtype)
                sub_ld_b: begin
                    mem_valid   = 1'b1;
                    load_signed = 1'b1;
                end
                sub_ld_h: begin
                    mem_valid   = 1'b1;
                    mem_size    = size_half;
                    load_signed = 1'b1;
                end
                sub_ld_w: begin
                    mem_valid = 1'b1;
                    mem_size  = size_word;
                end
                sub_st_b: begin
                    mem_valid = 1'b1;
                    mem_write = 1'b1;
                end
                sub_st_h: begin
                    mem_valid = 1'b1;
                    mem_write = 1'b1;
                    mem_size  = size_half;
                end
                sub_st_w: begin
                    mem_valid = 1'b1;
                    mem_write = 1'b1;
                    mem_size  = size_word;
                end
                sub_ld_bu: mem_valid = 1'b1;
                sub_ld_hu: begin
                    mem_valid = 1'b1;
                    mem_size  = size_half;
                end
                default: ; // cacop handled elsewhere
            endcase
        end else if (inst_type == inst_type_atomic) begin
            case (subtype)
                sub_ll_w: begin
                    mem_valid = 1'b1;
                    mem_size  = size_word;
                end
                sub_sc_w: begin
                    mem_valid = 1'b1;
                    mem_write = 1'b1;
                    mem_size  = size_word;
                    atomic_sc = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // little endian lanes
    always_comb begin
        case (mem_size)
            size_byte: begin
                lane_mask = 4'b0001 << offset;
                bad_align = 1'b0;
            end
            size_half: begin
                lane_mask = offset[1] ? 4'b1100 : 4'b0011;
                bad_align = offset[0];
            end
            default: begin
                lane_mask = 4'b1111;
                bad_align = |offset;
            end
        endcase
    end

    assign misaligned = mem_valid & bad_align;
    assign mem_wstrb  = (mem_valid && !bad_align) ? lane_mask : 4'b0000;

    always_comb begin
        mem_wdata = '0;
        if (mem_write) begin
            case (mem_size)
                size_byte: mem_wdata = {24'b0, rrd[7:0]} << {offset, 3'b000};
                size_half: mem_wdata = {16'b0, rrd[15:0]} << {offset[1], 4'b0000};
                default:   mem_wdata = rrd;
            endcase
        end
    end

    // store data only in strobed lanes
    always_comb begin
        if (mem_valid && !misaligned)
            assert final (mem_wstrb != 4'b0000 &&
                          (mem_wdata & ~{{8{mem_wstrb[3]}}, {8{mem_wstrb[2]}},
                                         {8{mem_wstrb[1]}}, {8{mem_wstrb[0]}}}) == '0)
                else $error("strobe does not cover the access, ctr=%h", ctr);
    end

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

    localparam int xlen       = 32;
    localparam int excp_arg_w = 16;

    // ctr field positions
    localparam int type_lsb    = 0;
    localparam int type_msb    = 3;
    localparam int subtype_lsb = 7;
    localparam int subtype_msb = 11;

    // instruction type field
    localparam logic [3:0] inst_type_mem    = 4'd5;
    localparam logic [3:0] inst_type_atomic = 4'd6;
    localparam logic [3:0] inst_type_ibar   = 4'd9;

    // subtypes under inst_type_mem
    localparam logic [4:0] sub_ld_b  = 5'd0;
    localparam logic [4:0] sub_ld_h  = 5'd1;
    localparam logic [4:0] sub_ld_w  = 5'd2;
    localparam logic [4:0] sub_st_b  = 5'd3;
    localparam logic [4:0] sub_st_h  = 5'd4;
    localparam logic [4:0] sub_st_w  = 5'd5;
    localparam logic [4:0] sub_ld_bu = 5'd6;
    localparam logic [4:0] sub_ld_hu = 5'd7;
    localparam logic [4:0] sub_cacop = 5'd8;

    // subtypes under inst_type_atomic
    localparam logic [4:0] sub_ll_w = 5'd11;
    localparam logic [4:0] sub_sc_w = 5'd12;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // cacop target, excp_arg[2:0]
    typedef enum logic [2:0] {
        tgt_icache = 3'd0,
        tgt_dcache = 3'd1, // dcache plus l2
        tgt_l2     = 3'd2
    } cacop_target_e;

    localparam logic [31:0] ibar_opcode = 32'h8000_0000;

endpackage
